// File: rtl/iagc_capture_cfg.svh
`ifndef IAGC_CAPTURE_CFG_SVH
`define IAGC_CAPTURE_CFG_SVH

// Data path widths.
`define IAGC_DATA_W        16
`define IAGC_ADDR_W        12
`define IAGC_DEC_W         4
`define IAGC_OP_W          3

`define IAGC_MEM_DEPTH     4096   // Physical RAM depth, also the default capture depth.
`define IAGC_DUMP_CREDITS  4      // Credits the dumper holds after reset.
`define IAGC_END_CYCLES    4      // Length of the end of capture pulse.

`endif

// File: rtl/iagc_types_pkg.sv
`default_nettype none

`include "iagc_capture_cfg.svh"

package iagc_types_pkg;

    // One ADC word of the reference or error channel.
    typedef logic [`IAGC_DATA_W-1:0] sample_t;

    // Sample memory address, also used for the capture depth.
    typedef logic [`IAGC_ADDR_W-1:0] addr_t;

    typedef logic [`IAGC_DEC_W-1:0] dec_t;   // Decimation factor, 0 and 1 keep every sample.

    // Holds the values 0 to IAGC_DUMP_CREDITS.
    typedef logic [$clog2(`IAGC_DUMP_CREDITS + 1)-1:0] credit_t;

endpackage

`default_nettype wire

// File: rtl/iagc_ctrl_pkg.sv
`default_nettype none

`include "iagc_capture_cfg.svh"

package iagc_ctrl_pkg;

    typedef enum logic [3:0] {
        STATUS_RESET     = 4'b0000,
        STATUS_INIT      = 4'b0001,
        STATUS_IDLE      = 4'b0010,
        STATUS_SAMPLE    = 4'b0011,
        STATUS_CMD_PARSE = 4'b0100,
        STATUS_CMD_READ  = 4'b0101,
        STATUS_CMD_ERROR = 4'b0110,
        STATUS_DUMP_REF  = 4'b0111,
        STATUS_DUMP_ERR  = 4'b1000,
        STATUS_CLEAN_MEM = 4'b1001,
        STATUS_SET_MEM   = 4'b1010,
        STATUS_SET_DEC   = 4'b1011,
        STATUS_HALT      = 4'b1100
    } iagc_status_e;

    // Host opcodes. Code 7 has no meaning and is answered with CMD_ERROR.
    typedef enum logic [`IAGC_OP_W-1:0] {
        OP_START     = 3'd0,
        OP_DUMP_REF  = 3'd1,
        OP_DUMP_ERR  = 3'd2,
        OP_CLEAN_MEM = 3'd3,
        OP_SET_MEM   = 3'd4,
        OP_SET_DEC   = 3'd5,
        OP_HALT      = 3'd6
    } iagc_op_e;

    typedef enum logic [1:0] {
        SMP_INIT  = 2'd0,
        SMP_WAIT  = 2'd1,
        SMP_WRITE = 2'd2,
        SMP_END   = 2'd3
    } sampler_state_e;

endpackage

`default_nettype wire

// File: rtl/sample_wr_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "iagc_capture_cfg.svh"

interface sample_wr_if import iagc_types_pkg::*; ();

    logic    valid;
    addr_t   addr;
    sample_t ref_sample;
    sample_t err_sample;

    // The memory stores the pair on the same edge that sees valid high.
    modport sampler (output valid, output addr, output ref_sample, output err_sample);
    modport mem     (input  valid, input  addr, input  ref_sample, input  err_sample);

endinterface

`default_nettype wire

// File: rtl/sample_rd_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "iagc_capture_cfg.svh"

interface sample_rd_if import iagc_types_pkg::*; ();

    logic    en;
    logic    sel;     // Low reads the reference RAM, high reads the error RAM.
    addr_t   addr;
    sample_t data;    // Valid one cycle after en.

    modport dumper (output en, output sel, output addr, input  data);
    modport mem    (input  en, input  sel, input  addr, output data);

endinterface

`default_nettype wire

// File: rtl/iagc_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "iagc_capture_cfg.svh"

module iagc_sequencer
    import iagc_types_pkg::*;
    import iagc_ctrl_pkg::*;
(
    input  wire logic                  i_clock,
    input  wire logic                  i_rst_n,
    input  wire logic                  i_cmd_valid,
    input  wire logic [`IAGC_OP_W-1:0] i_cmd_op,
    input  wire addr_t                 i_cmd_arg,
    input  wire logic                  i_capture_end,
    input  wire logic                  i_clear_done,
    input  wire logic                  i_dump_done,
    output iagc_status_e               o_status,
    output addr_t                      o_memory_size,
    output dec_t                       o_decimator,
    output logic                       o_cmd_error
);

    iagc_status_e next_status;
    iagc_op_e     op;
    logic         accept;
    logic         end_q;
    logic         end_fall;

    assign op       = iagc_op_e'(i_cmd_op);
    assign accept   = (o_status == STATUS_IDLE) && i_cmd_valid;
    assign end_fall = end_q && !i_capture_end;   // The sampler has finished its end pulse.

    always_comb begin
        next_status = o_status;
        case (o_status)
            STATUS_RESET: next_status = STATUS_INIT;
            STATUS_INIT:  next_status = STATUS_IDLE;
            STATUS_IDLE: begin
                if (i_cmd_valid) begin
                    case (op)
                        OP_START:     next_status = STATUS_SAMPLE;
                        OP_DUMP_REF:  next_status = STATUS_DUMP_REF;
                        OP_DUMP_ERR:  next_status = STATUS_DUMP_ERR;
                        OP_CLEAN_MEM: next_status = STATUS_CLEAN_MEM;
                        OP_SET_MEM:   next_status = STATUS_SET_MEM;
                        OP_SET_DEC:   next_status = STATUS_SET_DEC;
                        OP_HALT:      next_status = STATUS_HALT;
                        default:      next_status = STATUS_CMD_ERROR;
                    endcase
                end
            end
            STATUS_SAMPLE: begin
                if (end_fall) next_status = STATUS_IDLE;
            end
            STATUS_DUMP_REF, STATUS_DUMP_ERR: begin
                if (i_dump_done) next_status = STATUS_IDLE;
            end
            STATUS_CLEAN_MEM: begin
                if (i_clear_done) next_status = STATUS_IDLE;
            end
            STATUS_HALT: next_status = STATUS_HALT;   // Only a reset leaves HALT.
            default:     next_status = STATUS_IDLE;
        endcase
    end

    // A depth of IAGC_MEM_DEPTH wraps to zero in addr_t, and every block reads zero as the
    // full RAM. A SET_MEM argument of zero therefore selects the full depth as well.
    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_status      <= STATUS_RESET;
            o_memory_size <= addr_t'(`IAGC_MEM_DEPTH);
            o_decimator   <= dec_t'(1);
            end_q         <= 1'b0;
        end else begin
            o_status <= next_status;
            end_q    <= i_capture_end;
            if (accept && (op == OP_SET_MEM)) o_memory_size <= i_cmd_arg;
            if (accept && (op == OP_SET_DEC)) o_decimator <= i_cmd_arg[`IAGC_DEC_W-1:0];
        end
    end

    assign o_cmd_error = o_status == STATUS_CMD_ERROR;

endmodule

`default_nettype wire

// File: rtl/iagc_sampler.sv
`timescale 1ns/1ps
`default_nettype none

`include "iagc_capture_cfg.svh"

module iagc_sampler
    import iagc_types_pkg::*;
    import iagc_ctrl_pkg::*;
(
    input  wire logic         i_clock,
    input  wire logic         i_rst_n,
    input  wire iagc_status_e i_status,
    input  wire logic         i_gate,
    input  wire sample_t      i_reference,
    input  wire sample_t      i_error,
    input  wire addr_t        i_memory_size,
    input  wire dec_t         i_decimator,
    sample_wr_if.sampler      wr,
    output logic              o_end
);

    localparam int END_W = $clog2(`IAGC_END_CYCLES);
    localparam int END_LAST = `IAGC_END_CYCLES - 1;

    sampler_state_e   state;
    sampler_state_e   next_state;
    addr_t            addr;        // Address of the next write.
    addr_t            last_addr;
    dec_t             dec_cnt;
    logic [END_W-1:0] end_cnt;
    logic             gate_q;
    logic             gate_rise;
    logic             hit;

    assign last_addr = i_memory_size - addr_t'(1);
    assign gate_rise = i_gate && !gate_q;

    // Every decimation-th cycle with the gate high takes a sample.
    assign hit = (state == SMP_WRITE) && i_gate &&
                 ((i_decimator <= dec_t'(1)) || (dec_cnt == i_decimator - dec_t'(1)));

    always_comb begin
        next_state = state;
        case (state)
            SMP_INIT: begin
                if (i_status == STATUS_SAMPLE) next_state = SMP_WAIT;
            end
            SMP_WAIT: begin
                if (i_status != STATUS_SAMPLE) next_state = SMP_INIT;
                else if (gate_rise) next_state = SMP_WRITE;
            end
            SMP_WRITE: begin
                if (hit && (addr == last_addr)) next_state = SMP_END;
                else if (!i_gate) next_state = SMP_WAIT;
            end
            SMP_END: begin
                if (end_cnt == END_LAST[END_W-1:0]) next_state = SMP_INIT;
            end
            default: next_state = SMP_INIT;
        endcase
    end

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state    <= SMP_INIT;
            gate_q   <= 1'b0;
            addr     <= '0;
            dec_cnt  <= '0;
            end_cnt  <= '0;
            wr.valid <= 1'b0;
        end else begin
            gate_q   <= i_gate;
            wr.valid <= hit && (i_status != STATUS_RESET);
            state    <= (i_status == STATUS_RESET) ? SMP_INIT : next_state;
            case (state)
                SMP_INIT: begin
                    addr    <= '0;
                    dec_cnt <= '0;
                    end_cnt <= '0;
                end
                SMP_WAIT: dec_cnt <= '0;   // Each gate pulse starts a fresh count.
                SMP_WRITE: begin
                    if (hit) begin
                        addr    <= addr + addr_t'(1);
                        dec_cnt <= '0;
                    end else if (i_gate) begin
                        dec_cnt <= dec_cnt + dec_t'(1);
                    end
                end
                default: end_cnt <= end_cnt + 1'b1;
            endcase
        end
    end

    always_ff @(posedge i_clock) begin
        if (hit) begin
            wr.addr       <= addr;
            wr.ref_sample <= i_reference;
            wr.err_sample <= i_error;
        end
    end

    assign o_end = state == SMP_END;

endmodule

`default_nettype wire

// File: rtl/sample_memory.sv
`timescale 1ns/1ps
`default_nettype none

`include "iagc_capture_cfg.svh"

module sample_memory
    import iagc_types_pkg::*;
    import iagc_ctrl_pkg::*;
(
    input  wire logic         i_clock,
    input  wire logic         i_rst_n,
    input  wire iagc_status_e i_status,
    input  wire addr_t        i_memory_size,
    sample_wr_if.mem          wr,
    sample_rd_if.mem          rd,
    output logic              o_clear_done
);

    sample_t ref_ram [`IAGC_MEM_DEPTH];
    sample_t err_ram [`IAGC_MEM_DEPTH];

    addr_t   clr_addr;
    addr_t   last_addr;
    logic    clearing;
    logic    we;
    addr_t   waddr;
    sample_t wref;
    sample_t werr;

    assign clearing     = i_status == STATUS_CLEAN_MEM;
    assign last_addr    = i_memory_size - addr_t'(1);
    assign o_clear_done = clearing && (clr_addr == last_addr);

    // The clear sweep takes the write port away from the sampler.
    assign we    = clearing || wr.valid;
    assign waddr = clearing ? clr_addr : wr.addr;
    assign wref  = clearing ? '0 : wr.ref_sample;
    assign werr  = clearing ? '0 : wr.err_sample;

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) clr_addr <= '0;
        else clr_addr <= clearing ? clr_addr + addr_t'(1) : '0;
    end

    always_ff @(posedge i_clock) begin
        if (we) begin
            ref_ram[waddr] <= wref;
            err_ram[waddr] <= werr;
        end
        if (rd.en) rd.data <= rd.sel ? err_ram[rd.addr] : ref_ram[rd.addr];
    end

endmodule

`default_nettype wire

// File: rtl/sample_dumper.sv
`timescale 1ns/1ps
`default_nettype none

`include "iagc_capture_cfg.svh"

module sample_dumper
    import iagc_types_pkg::*;
    import iagc_ctrl_pkg::*;
(
    input  wire logic         i_clock,
    input  wire logic         i_rst_n,
    input  wire iagc_status_e i_status,
    input  wire addr_t        i_memory_size,
    input  wire logic         i_dump_credit,
    sample_rd_if.dumper       rd,
    output logic              o_dump_valid,
    output sample_t           o_dump_data,
    output logic              o_dump_last,
    output logic              o_done
);

    credit_t credits;
    addr_t   rd_addr;
    addr_t   last_addr;
    logic    active;
    logic    issued_all;
    logic    issue;

    assign active    = (i_status == STATUS_DUMP_REF) || (i_status == STATUS_DUMP_ERR);
    assign last_addr = i_memory_size - addr_t'(1);

    // The word in flight already holds one of the credits.
    assign issue = active && !issued_all && (credits > credit_t'(o_dump_valid));

    assign rd.en   = issue;
    assign rd.sel  = i_status == STATUS_DUMP_ERR;
    assign rd.addr = rd_addr;

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            credits      <= credit_t'(`IAGC_DUMP_CREDITS);
            rd_addr      <= '0;
            issued_all   <= 1'b0;
            o_dump_valid <= 1'b0;
            o_dump_last  <= 1'b0;
        end else begin
            credits      <= credits - credit_t'(o_dump_valid) + credit_t'(i_dump_credit);
            o_dump_valid <= issue;
            o_dump_last  <= issue && (rd_addr == last_addr);
            if (!active) begin
                rd_addr    <= '0;
                issued_all <= 1'b0;
            end else if (issue) begin
                rd_addr <= rd_addr + addr_t'(1);
                if (rd_addr == last_addr) issued_all <= 1'b1;
            end
        end
    end

    assign o_dump_data = rd.data;   // The RAM output register holds the word.
    assign o_done      = o_dump_valid && o_dump_last;

endmodule

`default_nettype wire

// File: rtl/iagc_capture_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "iagc_capture_cfg.svh"

module iagc_capture_top
    import iagc_types_pkg::*;
    import iagc_ctrl_pkg::*;
(
    input  wire logic                  i_clock,
    input  wire logic                  i_rst_n,
    input  wire logic                  i_cmd_valid,
    input  wire logic [`IAGC_OP_W-1:0] i_cmd_op,
    input  wire addr_t                 i_cmd_arg,
    input  wire logic                  i_gate,
    input  wire sample_t               i_reference,
    input  wire sample_t               i_error,
    output logic                       o_dump_valid,
    output sample_t                    o_dump_data,
    output logic                       o_dump_last,
    input  wire logic                  i_dump_credit,
    output iagc_status_e               o_status,
    output logic                       o_cmd_error,
    output logic                       o_capture_end
);

    addr_t memory_size;
    dec_t  decimator;
    logic  clear_done;
    logic  dump_done;

    sample_wr_if wr_bus ();
    sample_rd_if rd_bus ();

    iagc_sequencer u_sequencer (
        .i_clock       (i_clock),
        .i_rst_n       (i_rst_n),
        .i_cmd_valid   (i_cmd_valid),
        .i_cmd_op      (i_cmd_op),
        .i_cmd_arg     (i_cmd_arg),
        .i_capture_end (o_capture_end),
        .i_clear_done  (clear_done),
        .i_dump_done   (dump_done),
        .o_status      (o_status),
        .o_memory_size (memory_size),
        .o_decimator   (decimator),
        .o_cmd_error   (o_cmd_error)
    );

    iagc_sampler u_sampler (
        .i_clock       (i_clock),
        .i_rst_n       (i_rst_n),
        .i_status      (o_status),
        .i_gate        (i_gate),
        .i_reference   (i_reference),
        .i_error       (i_error),
        .i_memory_size (memory_size),
        .i_decimator   (decimator),
        .wr            (wr_bus.sampler),
        .o_end         (o_capture_end)
    );

    sample_memory u_memory (
        .i_clock       (i_clock),
        .i_rst_n       (i_rst_n),
        .i_status      (o_status),
        .i_memory_size (memory_size),
        .wr            (wr_bus.mem),
        .rd            (rd_bus.mem),
        .o_clear_done  (clear_done)
    );

    sample_dumper u_dumper (
        .i_clock       (i_clock),
        .i_rst_n       (i_rst_n),
        .i_status      (o_status),
        .i_memory_size (memory_size),
        .i_dump_credit (i_dump_credit),
        .rd            (rd_bus.dumper),
        .o_dump_valid  (o_dump_valid),
        .o_dump_data   (o_dump_data),
        .o_dump_last   (o_dump_last),
        .o_done        (dump_done)
    );

endmodule

`default_nettype wire

// File: verif/iagc_capture_props.sv
`timescale 1ns/1ps
`default_nettype none

`include "iagc_capture_cfg.svh"

module iagc_capture_props (
    input wire logic i_clock,
    input wire logic i_rst_n,
    input wire logic i_dump_valid,
    input wire logic i_dump_last,
    input wire logic i_dump_credit,
    input wire logic i_cmd_error,
    input wire logic i_capture_end
);

    int credits;   // Credits the dumper should hold, rebuilt from the stream itself.
    int end_run;   // Length of the current end pulse.

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            credits <= `IAGC_DUMP_CREDITS;
            end_run <= 0;
        end else begin
            credits <= credits - int'(i_dump_valid) + int'(i_dump_credit);
            end_run <= i_capture_end ? end_run + 1 : 0;
        end
    end

    credit_a: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        i_dump_valid |-> credits > 0)
        else $error("Dump word sent with no credit left");

    end_len_a: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        (!i_capture_end && end_run != 0) |-> end_run == `IAGC_END_CYCLES)
        else $error("End of capture pulse has the wrong length");

    cmd_err_a: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        i_cmd_error |=> !i_cmd_error)
        else $error("Command error held longer than one cycle");

    reset_a: assert property (@(posedge i_clock)
        $rose(i_rst_n) |-> !i_dump_valid && !i_dump_last && !i_cmd_error && !i_capture_end)
        else $error("Control outputs not low after reset");

endmodule

bind iagc_capture_top iagc_capture_props u_props (
    .i_clock       (i_clock),
    .i_rst_n       (i_rst_n),
    .i_dump_valid  (o_dump_valid),
    .i_dump_last   (o_dump_last),
    .i_dump_credit (i_dump_credit),
    .i_cmd_error   (o_cmd_error),
    .i_capture_end (o_capture_end)
);

`default_nettype wire

// File: verif/iagc_capture_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "iagc_capture_cfg.svh"

module iagc_capture_tb
    import iagc_types_pkg::*;
    import iagc_ctrl_pkg::*;
();

    localparam int      DEPTH      = 16;
    localparam int      TIMEOUT    = 2000;
    localparam int      HIGH_TICKS = 6;          // Gate high time before the interruption.
    localparam sample_t ERR_MASK   = 16'h5a3c;   // The error channel is the ramp with these bits flipped.

    logic                  i_clock = 1'b0;
    logic                  i_rst_n;
    logic                  i_cmd_valid;
    logic [`IAGC_OP_W-1:0] i_cmd_op;
    addr_t                 i_cmd_arg;
    logic                  i_gate;
    sample_t               i_reference;
    sample_t               i_error;
    logic                  i_dump_credit;
    logic                  o_dump_valid;
    sample_t               o_dump_data;
    logic                  o_dump_last;
    iagc_status_e          o_status;
    logic                  o_cmd_error;
    logic                  o_capture_end;

    integer  seed = 32'h4396_e521;
    sample_t dump_words[$];
    bit      dump_lasts[$];
    int      ret_delay[$];          // Cycles until each consumed word gives its credit back.
    bit      hold_credits = 1'b0;
    sample_t gate_ramp[2];          // Ramp value present when the gate rose, per gate pulse.

    iagc_capture_top UUT (.*);

    always #5 i_clock = ~i_clock;

    // The consumer takes words in the middle of the cycle.
    always @(negedge i_clock) begin
        if (o_dump_valid) begin
            dump_words.push_back(o_dump_data);
            dump_lasts.push_back(o_dump_last);
            ret_delay.push_back($unsigned($random(seed)) % 4);
        end
    end

    // Credits go back one per cycle, in the order the words arrived.
    always @(posedge i_clock) begin
        #1;
        foreach (ret_delay[k]) ret_delay[k] = ret_delay[k] - 1;
        if (!hold_credits && ret_delay.size() > 0 && ret_delay[0] < 0) begin
            void'(ret_delay.pop_front());
            i_dump_credit = 1'b1;
        end else begin
            i_dump_credit = 1'b0;
        end
    end

    // While the gate is high every step-th cycle after the rise is stored, so word n of a
    // pulse is the ramp value at the rise plus (n + 1) steps.
    function automatic sample_t expected_word(int index, int first_count, dec_t dec);
        int step;
        step = (dec <= dec_t'(1)) ? 1 : int'(dec);
        if (index < first_count) return gate_ramp[0] + sample_t'((index + 1) * step);
        return gate_ramp[1] + sample_t'((index - first_count + 1) * step);
    endfunction

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string test, input int expected, input int actual);
        $display("Error: %s expected %0h actual %0h", test, expected, actual);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic tick();
        @(posedge i_clock);
        #1;
        i_reference = i_reference + 1'b1;
        i_error     = i_reference ^ ERR_MASK;
    endtask

    task automatic send_cmd(input logic [`IAGC_OP_W-1:0] op, input addr_t arg);
        i_cmd_valid = 1'b1;
        i_cmd_op    = op;
        i_cmd_arg   = arg;
        tick();
        i_cmd_valid = 1'b0;
    endtask

    // A setting command shows its own status for one cycle and then IDLE.
    task automatic set_config(input iagc_op_e op, input addr_t arg,
                              input iagc_status_e status, input string test);
        send_cmd(op, arg);
        assert (o_status == status) else report_mismatch(test, status, o_status);
        tick();
        assert (o_status == STATUS_IDLE) else report_mismatch(test, STATUS_IDLE, o_status);
    endtask

    task automatic wait_status(input iagc_status_e status, input string test);
        int n;
        n = 0;
        while (o_status != status) begin
            if (n == TIMEOUT) abort_run({"Timeout in ", test, " waiting for ", status.name()});
            tick();
            n++;
        end
    endtask

    task automatic wait_capture_end(input string test);
        int n;
        n = 0;
        while (!o_capture_end) begin
            if (n == TIMEOUT) abort_run({"Timeout in ", test, " waiting for the capture end"});
            tick();
            n++;
        end
    endtask

    // A nonzero high_ticks drops the gate for three cycles after that many cycles high.
    task automatic run_capture(input int high_ticks, input string test);
        send_cmd(OP_START, '0);
        assert (o_status == STATUS_SAMPLE) else report_mismatch(test, STATUS_SAMPLE, o_status);
        tick();   // The sampler now waits for the gate.
        gate_ramp[0] = i_reference;
        gate_ramp[1] = i_reference;
        i_gate = 1'b1;
        if (high_ticks > 0) begin
            repeat (high_ticks) tick();
            i_gate = 1'b0;
            repeat (3) tick();
            gate_ramp[1] = i_reference;
            i_gate = 1'b1;
        end
        wait_capture_end(test);
        wait_status(STATUS_IDLE, test);
        i_gate = 1'b0;
    endtask

    task automatic dump_check(input iagc_op_e op, input dec_t dec, input int first_count,
                              input bit zeros, input bit hold, input string test);
        sample_t exp;
        int      n;
        n = 0;
        while (ret_delay.size() != 0) begin
            if (n == TIMEOUT) abort_run({"Timeout in ", test, " waiting for credits"});
            tick();
            n++;
        end
        repeat (2) tick();
        dump_words.delete();
        dump_lasts.delete();
        hold_credits = hold;
        send_cmd(op, '0);
        if (hold) begin
            repeat (20) tick();
            assert (dump_words.size() <= `IAGC_DUMP_CREDITS)
                else report_mismatch({test, " words without credit return"},
                                     `IAGC_DUMP_CREDITS, dump_words.size());
            hold_credits = 1'b0;
        end
        wait_status(STATUS_IDLE, test);
        assert (dump_words.size() == DEPTH)
            else report_mismatch({test, " word count"}, DEPTH, dump_words.size());
        foreach (dump_words[k]) begin
            if (zeros) exp = '0;
            else exp = expected_word(k, first_count, dec) ^ ((op == OP_DUMP_ERR) ? ERR_MASK : '0);
            assert (dump_words[k] == exp)
                else report_mismatch($sformatf("%s word %0d", test, k), exp, dump_words[k]);
            assert (dump_lasts[k] == (k == DEPTH - 1))
                else report_mismatch($sformatf("%s last %0d", test, k), k == DEPTH - 1,
                                     dump_lasts[k]);
        end
    endtask

    initial begin
        int clean_cycles;
        i_rst_n       = 1'b0;
        i_cmd_valid   = 1'b0;
        i_cmd_op      = '0;
        i_cmd_arg     = '0;
        i_gate        = 1'b0;
        i_dump_credit = 1'b0;
        i_reference   = sample_t'($random(seed));
        i_error       = i_reference ^ ERR_MASK;
        repeat (4) tick();
        i_rst_n = 1'b1;
        assert (o_status == STATUS_RESET) else report_mismatch("reset", STATUS_RESET, o_status);
        tick();
        assert (o_status == STATUS_INIT) else report_mismatch("reset", STATUS_INIT, o_status);
        tick();
        assert (o_status == STATUS_IDLE) else report_mismatch("reset", STATUS_IDLE, o_status);

        send_cmd(3'd7, '0);
        assert (o_cmd_error) else report_mismatch("illegal opcode", 1, o_cmd_error);
        tick();
        assert (!o_cmd_error && o_status == STATUS_IDLE)
            else abort_run("Illegal opcode did not return to IDLE after one cycle");
        set_config(OP_SET_MEM, addr_t'(DEPTH), STATUS_SET_MEM, "set depth");
        set_config(OP_SET_DEC, addr_t'(3), STATUS_SET_DEC, "set decimation");

        run_capture(0, "decimated capture");
        dump_check(OP_DUMP_REF, dec_t'(3), DEPTH, 1'b0, 1'b0, "reference dump");
        dump_check(OP_DUMP_ERR, dec_t'(3), DEPTH, 1'b0, 1'b0, "error dump");

        set_config(OP_SET_DEC, addr_t'(1), STATUS_SET_DEC, "set decimation");
        run_capture(HIGH_TICKS, "gate interruption");
        dump_check(OP_DUMP_REF, dec_t'(1), HIGH_TICKS - 1, 1'b0, 1'b0, "interrupted dump");
        dump_check(OP_DUMP_REF, dec_t'(1), HIGH_TICKS - 1, 1'b0, 1'b1, "back-pressure dump");

        send_cmd(OP_CLEAN_MEM, '0);
        clean_cycles = 0;
        while (o_status == STATUS_CLEAN_MEM) begin
            if (clean_cycles == TIMEOUT) abort_run("Timeout while the memory clean ran");
            tick();
            clean_cycles++;
        end
        assert (clean_cycles == DEPTH) else report_mismatch("clean length", DEPTH, clean_cycles);
        dump_check(OP_DUMP_REF, dec_t'(1), DEPTH, 1'b1, 1'b0, "cleared dump");

        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: iagc_capture.f
+incdir+rtl
rtl/iagc_types_pkg.sv
rtl/iagc_ctrl_pkg.sv
rtl/sample_wr_if.sv
rtl/sample_rd_if.sv
rtl/iagc_sequencer.sv
rtl/iagc_sampler.sv
rtl/sample_memory.sv
rtl/sample_dumper.sv
rtl/iagc_capture_top.sv
verif/iagc_capture_props.sv
verif/iagc_capture_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        ?= iagc_capture_tb
FILELIST   ?= iagc_capture.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
